/* verilog/spaceGame_params.svh */
`ifndef SPACEGAME_PARAMS_SVH
`define SPACEGAME_PARAMS_SVH

// Horizontal raster, 20 cycles per line
`define H_ACTIVE 16
`define H_FRONT 1
`define H_SYNC 2
`define H_BACK 1

// Vertical raster, 15 lines per frame
`define V_ACTIVE 12
`define V_FRONT 1
`define V_SYNC 1
`define V_BACK 1

// Player sprite box
`define PLAYER_W 4
`define PLAYER_H 2
`define PLAYER_Y 8
`define PLAYER_START_X 6

// First row of the ground band
`define GROUND_Y 10

`define SKY_RGB 8'h03
`define GROUND_RGB 8'h1C
`define PLAYER_RGB 8'hE0

`endif

/* verilog/videoPkg.sv */
package videoPkg;

    // Raster column or row
    typedef logic [10:0] pixelCoord_t;

    // 3-3-2 colour word
    typedef logic [7:0] rgb_t;

endpackage

/* verilog/spritePkg.sv */
package spritePkg;

    // One request bit per object, index 0 is the player
    typedef logic [0:0] drawReq_t;

    // Left edge of the player, signed like the screen object positions
    typedef logic signed [10:0] playerPos_t;

endpackage

/* verilog/videoTiming.sv */
`include "spaceGame_params.svh"

module videoTiming (
    input  logic                  clk,
    input  logic                  rst,
    output videoPkg::pixelCoord_t pixelX,
    output videoPkg::pixelCoord_t pixelY,
    output logic                  active,
    output logic                  hSyncRaw,
    output logic                  vSyncRaw,
    output logic                  startOfFrame
);
    import videoPkg::*;

    localparam pixelCoord_t lastCol =
        pixelCoord_t'(`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK - 1);
    localparam pixelCoord_t lastRow =
        pixelCoord_t'(`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK - 1);
    localparam pixelCoord_t hSyncStart = pixelCoord_t'(`H_ACTIVE + `H_FRONT);
    localparam pixelCoord_t hSyncEnd = pixelCoord_t'(`H_ACTIVE + `H_FRONT + `H_SYNC);
    localparam pixelCoord_t vSyncStart = pixelCoord_t'(`V_ACTIVE + `V_FRONT);
    localparam pixelCoord_t vSyncEnd = pixelCoord_t'(`V_ACTIVE + `V_FRONT + `V_SYNC);
    localparam pixelCoord_t hVisible = pixelCoord_t'(`H_ACTIVE);
    localparam pixelCoord_t vVisible = pixelCoord_t'(`V_ACTIVE);

    pixelCoord_t hCount;
    pixelCoord_t vCount;
    logic        lineEnd;

    assign lineEnd = (hCount == lastCol);

    // Raster never stalls
    always_ff @(posedge clk) begin
        if (rst) begin
            hCount <= '0;
            vCount <= '0;
        end else if (lineEnd) begin
            hCount <= '0;
            if (vCount == lastRow) begin
                vCount <= '0;
            end else begin
                vCount <= vCount + 1'b1;
            end
        end else begin
            hCount <= hCount + 1'b1;
        end
    end

    assign pixelX = hCount;
    assign pixelY = vCount;

    assign active = (hCount < hVisible) && (vCount < vVisible);
    assign hSyncRaw = (hCount >= hSyncStart) && (hCount < hSyncEnd);
    assign vSyncRaw = (vCount >= vSyncStart) && (vCount < vSyncEnd);

    // Top-left corner of the raster
    assign startOfFrame = (hCount == '0) && (vCount == '0);

endmodule

/* verilog/playerSprite.sv */
`include "spaceGame_params.svh"

module playerSprite (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  moveLeft,
    input  logic                  moveRight,
    input  logic                  startOfFrame,
    input  videoPkg::pixelCoord_t pixelX,
    input  videoPkg::pixelCoord_t pixelY,
    output logic                  playerDraw,
    output videoPkg::rgb_t        playerRgb
);
    import videoPkg::*;
    import spritePkg::*;

    localparam playerPos_t startX = playerPos_t'(`PLAYER_START_X);
    localparam playerPos_t minX = playerPos_t'(0);
    localparam playerPos_t maxX = playerPos_t'(`H_ACTIVE - `PLAYER_W);
    localparam playerPos_t stepX = playerPos_t'(1);
    localparam pixelCoord_t spriteWidth = pixelCoord_t'(`PLAYER_W);
    localparam pixelCoord_t topRow = pixelCoord_t'(`PLAYER_Y);
    localparam pixelCoord_t bottomRow = pixelCoord_t'(`PLAYER_Y + `PLAYER_H - 1);

    playerPos_t  posX;
    playerPos_t  nextX;
    pixelCoord_t leftCol;
    logic        inColumns;
    logic        inRows;

    // One step per frame, held at the screen edges
    always_comb begin
        nextX = posX;
        if (moveRight && !moveLeft) begin
            if (posX < maxX) begin
                nextX = posX + stepX;
            end
        end else if (moveLeft && !moveRight) begin
            if (posX > minX) begin
                nextX = posX - stepX;
            end
        end
    end

    // New position covers the whole frame that starts here
    always_ff @(posedge clk) begin
        if (rst) begin
            posX <= startX;
        end else if (startOfFrame) begin
            posX <= nextX;
        end
    end

    // Position is clamped, so never negative
    assign leftCol = pixelCoord_t'(posX);

    assign inColumns = (pixelX >= leftCol) && (pixelX < leftCol + spriteWidth);
    assign inRows = (pixelY >= topRow) && (pixelY <= bottomRow);

    assign playerDraw = inColumns && inRows;
    assign playerRgb = `PLAYER_RGB;

endmodule

/* verilog/backgroundPattern.sv */
`include "spaceGame_params.svh"

module backgroundPattern (
    input  videoPkg::pixelCoord_t pixelY,
    output videoPkg::rgb_t        backgroundRgb
);
    import videoPkg::*;

    localparam pixelCoord_t groundTop = pixelCoord_t'(`GROUND_Y);
    localparam rgb_t skyRgb = `SKY_RGB;
    localparam rgb_t groundRgb = `GROUND_RGB;

    // Sky above the ground band
    always_comb begin
        if (pixelY >= groundTop) begin
            backgroundRgb = groundRgb;
        end else begin
            backgroundRgb = skyRgb;
        end
    end

endmodule

/* verilog/pixelMixer.sv */
module pixelMixer (
    input  logic                clk,
    input  logic                rst,
    input  spritePkg::drawReq_t drawRequests,
    input  videoPkg::rgb_t      playerRgb,
    input  videoPkg::rgb_t      backgroundRgb,
    input  logic                active,
    input  logic                hSyncRaw,
    input  logic                vSyncRaw,
    output videoPkg::rgb_t      rgb,
    output logic                hSync,
    output logic                vSync,
    output logic                blank
);
    import videoPkg::*;

    rgb_t mixedRgb;
    rgb_t visibleRgb;

    // Lowest index wins, background last
    always_comb begin
        mixedRgb = backgroundRgb;
        if (drawRequests[0]) begin
            mixedRgb = playerRgb;
        end
    end

    assign visibleRgb = active ? mixedRgb : '0;

    // Colour and syncs share one register stage
    always_ff @(posedge clk) begin
        if (rst) begin
            rgb <= '0;
            hSync <= 1'b0;
            vSync <= 1'b0;
            blank <= 1'b1;
        end else begin
            rgb <= visibleRgb;
            hSync <= hSyncRaw;
            vSync <= vSyncRaw;
            blank <= !active;
        end
    end

endmodule

/* verilog/spaceGameTop.sv */
module spaceGameTop (
    input  logic           clk,
    input  logic           rst,
    input  logic           moveLeft,
    input  logic           moveRight,
    output videoPkg::rgb_t rgb,
    output logic           hSync,
    output logic           vSync,
    output logic           blank
);
    import videoPkg::*;
    import spritePkg::*;

    pixelCoord_t pixelX;
    pixelCoord_t pixelY;
    logic        active;
    logic        hSyncRaw;
    logic        vSyncRaw;
    logic        startOfFrame;

    logic        playerDraw;
    rgb_t        playerRgb;
    rgb_t        backgroundRgb;
    drawReq_t    drawRequests;

    videoTiming videoTiming_i (
        .clk          (clk),
        .rst          (rst),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .active       (active),
        .hSyncRaw     (hSyncRaw),
        .vSyncRaw     (vSyncRaw),
        .startOfFrame (startOfFrame));

    playerSprite playerSprite_i (
        .clk          (clk),
        .rst          (rst),
        .moveLeft     (moveLeft),
        .moveRight    (moveRight),
        .startOfFrame (startOfFrame),
        .pixelX       (pixelX),
        .pixelY       (pixelY),
        .playerDraw   (playerDraw),
        .playerRgb    (playerRgb));

    backgroundPattern backgroundPattern_i (
        .pixelY        (pixelY),
        .backgroundRgb (backgroundRgb));

    // Player is the only object
    assign drawRequests = playerDraw;

    pixelMixer pixelMixer_i (
        .clk           (clk),
        .rst           (rst),
        .drawRequests  (drawRequests),
        .playerRgb     (playerRgb),
        .backgroundRgb (backgroundRgb),
        .active        (active),
        .hSyncRaw      (hSyncRaw),
        .vSyncRaw      (vSyncRaw),
        .rgb           (rgb),
        .hSync         (hSync),
        .vSync         (vSync),
        .blank         (blank));

endmodule

/* bench/spaceGameTop_props.sv */
`include "spaceGame_params.svh"

module spaceGameTop_props (
    input logic           clk,
    input logic           rst,
    input videoPkg::rgb_t rgb,
    input logic           hSync,
    input logic           blank
);
    logic [3:0] hSyncLength;

    // Cycles of the current hSync pulse so far
    always_ff @(posedge clk) begin
        if (rst) begin
            hSyncLength <= '0;
        end else if (hSync) begin
            hSyncLength <= hSyncLength + 1'b1;
        end else begin
            hSyncLength <= '0;
        end
    end

    blankMeansBlack: assert property (@(posedge clk) disable iff (rst) blank |-> rgb == '0)
        else $error("rgb is not zero while blank is high");

    hSyncWidth: assert property (@(posedge clk) disable iff (rst)
        $fell(hSync) |-> hSyncLength == 4'(`H_SYNC))
        else $error("hSync pulse has the wrong length");

endmodule

bind spaceGameTop spaceGameTop_props spaceGameTop_props_i (
    .clk   (clk),
    .rst   (rst),
    .rgb   (rgb),
    .hSync (hSync),
    .blank (blank));

/* bench/spaceGameTb.sv */
`include "spaceGame_params.svh"

module spaceGameTb;
    import videoPkg::*;

    localparam int lineLength = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int lineCount = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int hSyncStart = `H_ACTIVE + `H_FRONT;
    localparam int vSyncStart = `V_ACTIVE + `V_FRONT;
    localparam int maxPlayerX = `H_ACTIVE - `PLAYER_W;
    // Frames run by all tests together
    localparam int totalFrames = 58;
    localparam int clockPeriod = 100;
    localparam int watchdogTime = totalFrames * lineLength * lineCount * 2 * clockPeriod;

    logic   clk = 1'b0;
    logic   rst;
    logic   moveLeft;
    logic   moveRight;
    rgb_t   rgb;
    logic   hSync;
    logic   vSync;
    logic   blank;

    int     playerX;
    int     errorCount;
    int     checkCount;
    int     testCount;
    integer seed;
    rgb_t   rowRgb [0:`H_ACTIVE-1];
    int     visibleCount [0:lineCount-1];
    int     hSyncCount [0:lineCount-1];

    spaceGameTop spaceGameTop_i (
        .clk       (clk),
        .rst       (rst),
        .moveLeft  (moveLeft),
        .moveRight (moveRight),
        .rgb       (rgb),
        .hSync     (hSync),
        .vSync     (vSync),
        .blank     (blank));

    always #(clockPeriod / 2) clk = ~clk;

    function automatic int nextPlayerX(input int x, input logic left, input logic right);
        int moved;
        moved = x;
        if (right && !left) begin
            moved = x + 1;
        end else if (left && !right) begin
            moved = x - 1;
        end
        if (moved < 0) begin
            moved = 0;
        end else if (moved > maxPlayerX) begin
            moved = maxPlayerX;
        end
        return moved;
    endfunction

    function automatic rgb_t expectedRgb(input int h, input int v, input int x);
        if (h >= `H_ACTIVE || v >= `V_ACTIVE) begin
            return '0;
        end
        if (h >= x && h < x + `PLAYER_W && v >= `PLAYER_Y && v < `PLAYER_Y + `PLAYER_H) begin
            return `PLAYER_RGB;
        end
        if (v >= `GROUND_Y) begin
            return `GROUND_RGB;
        end
        return `SKY_RGB;
    endfunction

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("CHECK FAILED %s: got %0h, expected %0h", name, actual, expected);
        end
    endtask

    task automatic inspectPixel(input int h, input int v);
        logic visible;
        logic expHSync;
        logic expVSync;
        visible = (h < `H_ACTIVE) && (v < `V_ACTIVE);
        expHSync = (h >= hSyncStart) && (h < hSyncStart + `H_SYNC);
        expVSync = (v >= vSyncStart) && (v < vSyncStart + `V_SYNC);
        compareValue($sformatf("rgb at %0d,%0d", h, v), 32'(rgb),
                     32'(expectedRgb(h, v, playerX)));
        compareValue($sformatf("hSync at %0d,%0d", h, v), 32'(hSync), 32'(expHSync));
        compareValue($sformatf("vSync at %0d,%0d", h, v), 32'(vSync), 32'(expVSync));
        compareValue($sformatf("blank at %0d,%0d", h, v), 32'(blank), 32'(!visible));
        if (!blank) begin
            visibleCount[v]++;
        end
        if (hSync) begin
            hSyncCount[v]++;
        end
        if (v == `PLAYER_Y && visible) begin
            rowRgb[h] = rgb;
        end
    endtask

    // Starts with the counters at the top-left corner and ends there again
    task automatic runFrame(input logic left, input logic right);
        int h;
        int v;
        moveLeft = left;
        moveRight = right;
        playerX = nextPlayerX(playerX, left, right);
        for (v = 0; v < lineCount; v++) begin
            visibleCount[v] = 0;
            hSyncCount[v] = 0;
        end
        for (v = 0; v < lineCount; v++) begin
            for (h = 0; h < lineLength; h++) begin
                @(posedge clk);
                #10;
                inspectPixel(h, v);
            end
        end
    endtask

    // Sprite row lies in the sky
    task automatic verifySpritePosition(input int col);
        int   c;
        rgb_t expected;
        for (c = 0; c < `H_ACTIVE; c++) begin
            expected = (c >= col && c < col + `PLAYER_W) ? `PLAYER_RGB : `SKY_RGB;
            compareValue($sformatf("sprite row rgb at column %0d", c), 32'(rowRgb[c]),
                         32'(expected));
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testCount++;
        $display("%s finished with %0d errors", name, errorCount - errorsBefore);
    endtask

    task automatic resetAndRaster();
        int errorsBefore;
        int visibleLines;
        int v;
        errorsBefore = errorCount;
        visibleLines = 0;
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #10;
        rst = 1'b0;
        playerX = `PLAYER_START_X;
        compareValue("blank after reset", 32'(blank), 32'(1'b1));
        compareValue("rgb after reset", 32'(rgb), 32'(8'h00));
        compareValue("hSync after reset", 32'(hSync), 32'(1'b0));
        compareValue("vSync after reset", 32'(vSync), 32'(1'b0));
        runFrame(1'b0, 1'b0);
        for (v = 0; v < lineCount; v++) begin
            compareValue($sformatf("unblanked cycles in line %0d", v), visibleCount[v],
                         (v < `V_ACTIVE) ? `H_ACTIVE : 0);
            compareValue($sformatf("hSync cycles in line %0d", v), hSyncCount[v], `H_SYNC);
            if (visibleCount[v] > 0) begin
                visibleLines++;
            end
        end
        compareValue("unblanked lines", visibleLines, `V_ACTIVE);
        reportTest("reset and raster", errorsBefore);
    endtask

    task automatic idleFrame();
        int errorsBefore;
        errorsBefore = errorCount;
        runFrame(1'b0, 1'b0);
        verifySpritePosition(`PLAYER_START_X);
        reportTest("idle frame", errorsBefore);
    endtask

    task automatic moveRightThreeFrames();
        int errorsBefore;
        errorsBefore = errorCount;
        repeat (3) runFrame(1'b0, 1'b1);
        runFrame(1'b0, 1'b0);
        verifySpritePosition(`PLAYER_START_X + 3);
        reportTest("move right", errorsBefore);
    endtask

    task automatic clampAtEdges();
        int errorsBefore;
        errorsBefore = errorCount;
        repeat (10) runFrame(1'b0, 1'b1);
        runFrame(1'b0, 1'b0);
        verifySpritePosition(maxPlayerX);
        repeat (15) runFrame(1'b1, 1'b0);
        runFrame(1'b0, 1'b0);
        verifySpritePosition(0);
        reportTest("clamp at edges", errorsBefore);
    endtask

    task automatic bothAndRandomKeys();
        int errorsBefore;
        int heldX;
        int key;
        errorsBefore = errorCount;
        heldX = playerX;
        repeat (4) runFrame(1'b1, 1'b1);
        verifySpritePosition(heldX);
        repeat (20) begin
            key = $random(seed) & 3;
            // Both keys pressed becomes no key
            if (key == 3) begin
                key = 0;
            end
            runFrame(key[1], key[0]);
        end
        runFrame(1'b0, 1'b0);
        verifySpritePosition(playerX);
        reportTest("both and random keys", errorsBefore);
    endtask

    initial begin
        #(watchdogTime);
        $display("Watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        moveLeft = 1'b0;
        moveRight = 1'b0;
        seed = 55432;
        errorCount = 0;
        checkCount = 0;
        testCount = 0;
        playerX = `PLAYER_START_X;
        resetAndRaster();
        idleFrame();
        moveRightThreeFrames();
        clampAtEdges();
        bothAndRandomKeys();
        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* spaceGame.f */
+incdir+verilog
verilog/videoPkg.sv
verilog/spritePkg.sv
verilog/videoTiming.sv
verilog/playerSprite.sv
verilog/backgroundPattern.sv
verilog/pixelMixer.sv
verilog/spaceGameTop.sv
bench/spaceGameTop_props.sv
bench/spaceGameTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module spaceGameTb -f spaceGame.f -o spaceGameSim

# A failed run still leaves its output for the search below
output=$(./obj_dir/spaceGameSim) || true
printf '%s\n' "$output"

printf '%s\n' "$output" | grep -qx "Everything OK"
